// File: hw/scroll_pkg.sv
package scroll_pkg;

	// Scrolled beam position, low three bits of h are the pixel phase
	typedef struct packed {
		logic [8:0] h;
		logic [8:0] v;
	} scroll_pos_t;

	// CPU scroll offsets
	typedef struct packed {
		logic [8:0] hpos;
		logic [8:0] vpos;
	} scroll_ofs_t;

	// Attribute byte in the upper half of tile RAM
	typedef struct packed {
		logic [1:0] code_hi;	// Tile code bits 9..8
		logic       vflip;
		logic       hflip;	// Low means mirrored
		logic       spare;
		logic [2:0] pal;
	} tile_attr_t;

	typedef struct packed {
		logic [2:0] pal;
		logic [2:0] col;
	} pixel_t;

	// Tile RAM owner
	typedef enum logic [1:0] {
		ST_SCAN,
		ST_WINDOW,
		ST_READY
	} fetch_state_t;

endpackage

// File: hw/scroll_regs.sv
`timescale 1ns/1ps

module scroll_regs(
	input  logic                     clk,
	input  logic                     reset,
	input  logic                     scrpos_cs,
	input  logic [3:0]               cpu_addr,
	input  logic [7:0]               cpu_din,
	output scroll_pkg::scroll_ofs_t  ofs
);

	always_ff @(posedge clk) begin
		if (reset) begin
			ofs <= '0;
		end else if (scrpos_cs && cpu_addr[3]) begin
			case (cpu_addr[2:0])
				3'd0: ofs.hpos[7:0] <= cpu_din;
				3'd1: ofs.hpos[8]   <= cpu_din[0];
				3'd2: ofs.vpos[7:0] <= cpu_din;
				3'd3: ofs.vpos[8]   <= cpu_din[0];
				default: ;	// Other offsets not decoded
			endcase
		end
	end

endmodule

// File: hw/scroll_position.sv
`timescale 1ns/1ps

module scroll_position(
	input  logic                     clk,
	input  logic                     reset,
	input  logic [8:0]               h,
	input  logic [7:0]               v,
	input  logic                     flip,
	input  scroll_pkg::scroll_ofs_t  ofs,
	output scroll_pkg::scroll_pos_t  pos
);

	logic [8:0] hf;
	logic [7:0] vf;
	logic [8:0] hsum;
	logic [8:0] vsum;

	assign hf = {h[8], h[7:0] ^ {8{flip}}};
	assign vf = v ^ {8{flip}};

	always_comb begin
		hsum = ofs.hpos + hf;	// Wraps at 9 bits
		vsum = ofs.vpos + {1'b0, vf};
	end

	// Phase bits turned back so the pixel timer still counts up when flipped
	always_ff @(posedge clk) begin
		if (reset) begin
			pos <= '0;
		end else begin
			pos.h <= {hsum[8:3], hsum[2:0] ^ {3{flip}}};
			pos.v <= vsum;
		end
	end

endmodule

// File: hw/tile_ram.sv
`timescale 1ns/1ps

module tile_ram #(
	parameter int RAM_AW = 11
) (
	input  logic              clk,
	input  logic [RAM_AW-1:0] addr,
	input  logic [7:0]        din,
	input  logic              we,
	output logic [7:0]        q
);

	logic [7:0] mem [2**RAM_AW];

	// Read returns the old byte on a write cycle
	always_ff @(posedge clk) begin
		if (we)
			mem[addr] <= din;
		q <= mem[addr];
	end

endmodule

// File: hw/tile_fetch_fsm.sv
`timescale 1ns/1ps

module tile_fetch_fsm(
	input  logic                     clk,
	input  logic                     reset,
	input  scroll_pkg::scroll_pos_t  pos,
	input  logic                     flip,
	input  logic                     scr_cs,
	input  logic                     rd,
	input  logic [10:0]              cpu_addr,
	output logic [10:0]              ram_addr,
	output logic                     ram_we,
	input  logic [7:0]               ram_q,
	output logic                     cpu_ready,
	output logic [14:0]              rom_addr,
	output logic [2:0]               pal,
	output logic                     mirror
);
	import scroll_pkg::*;

	fetch_state_t state;
	logic [2:0]   phase;
	logic [7:0]   code_lo;
	tile_attr_t   attr;
	logic         tile_mirror;
	logic         row_flip;
	logic [2:0]   pal_next;
	logic         mirror_next;

	assign phase       = pos.h[2:0];
	assign attr        = tile_attr_t'(ram_q);
	assign tile_mirror = ~attr.hflip ^ flip;
	assign row_flip    = attr.vflip ^ flip;

	// Scan owns phases 0..3, CPU window sits in 4..7
	always_comb begin
		if (state == ST_SCAN) begin
			ram_addr = {pos.h[1], pos.h[8:4], pos.v[8:4]};	// Attribute half at phases 2,3
			ram_we   = 1'b0;
		end else begin
			ram_addr = cpu_addr;
			ram_we   = scr_cs && !rd;
		end
	end

	assign cpu_ready = !scr_cs || state == ST_READY;

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= ST_SCAN;
		end else begin
			case (state)
				ST_SCAN:
					if (phase == 3'd3 && scr_cs)
						state <= ST_WINDOW;
				ST_WINDOW:
					if (phase == 3'd5)
						state <= ST_READY;
				ST_READY:
					if (phase == 3'd7)
						state <= ST_SCAN;
				default:
					state <= ST_SCAN;
			endcase
		end
	end

	// Code and attribute capture
	always_ff @(posedge clk) begin
		if (phase == 3'd1)
			code_lo <= ram_q;
		if (phase == 3'd3) begin
			pal_next    <= attr.pal;
			mirror_next <= tile_mirror;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			rom_addr <= '0;
			pal      <= '0;
			mirror   <= 1'b0;
		end else begin
			if (phase == 3'd3)
				rom_addr <= {attr.code_hi, code_lo, pos.h[3] ^ tile_mirror,
					pos.v[3:0] ^ {4{row_flip}}};
			// Handed over just before the shifter loads this tile's word
			if (phase == 3'd7) begin
				pal    <= pal_next;
				mirror <= mirror_next;
			end
		end
	end

endmodule

// File: hw/pixel_shifter.sv
`timescale 1ns/1ps

module pixel_shifter(
	input  logic                clk,
	input  logic                reset,
	input  logic [2:0]          phase,
	input  logic [23:0]         rom_data,
	input  logic [2:0]          pal,
	input  logic                mirror,
	output scroll_pkg::pixel_t  pixel
);
	import scroll_pkg::*;

	// Load to first pixel out, giving 16 clocks from the ROM address update
	localparam int DELAY = 11;

	logic [2:0][7:0]        planes;
	logic [2:0]             pal_cur;
	logic                   mirror_cur;
	pixel_t                 out_px;
	pixel_t [DELAY-1:0]     dly;

	always_comb begin
		out_px.pal = pal_cur;
		if (mirror_cur)
			out_px.col = {planes[0][0], planes[1][0], planes[2][0]};
		else
			out_px.col = {planes[0][7], planes[1][7], planes[2][7]};
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			planes     <= '0;
			pal_cur    <= '0;
			mirror_cur <= 1'b0;
		end else if (phase == 3'd0) begin
			planes     <= rom_data;
			pal_cur    <= pal;
			mirror_cur <= mirror;
		end else begin
			for (int i = 0; i < 3; i++) begin
				if (mirror_cur)
					planes[i] <= {1'b0, planes[i][7:1]};
				else
					planes[i] <= {planes[i][6:0], 1'b0};
			end
		end
	end

	always_ff @(posedge clk) begin
		if (reset)
			dly <= '0;
		else
			dly <= {dly[DELAY-2:0], out_px};
	end

	assign pixel = dly[DELAY-1];

endmodule

// File: hw/scroll_layer.sv
`timescale 1ns/1ps

module scroll_layer #(
	parameter int RAM_AW = 11
) (
	input  logic                clk,
	input  logic                reset,
	input  logic [10:0]         cpu_addr,
	input  logic [7:0]          cpu_din,
	output logic [7:0]          cpu_dout,
	input  logic                rd,
	input  logic                scr_cs,
	input  logic                scrpos_cs,
	input  logic                flip,
	input  logic [8:0]          h,
	input  logic [7:0]          v,
	output logic                cpu_ready,
	output logic [14:0]         rom_addr,
	input  logic [23:0]         rom_data,
	output scroll_pkg::pixel_t  pixel
);
	import scroll_pkg::*;

	scroll_ofs_t      ofs;
	scroll_pos_t      pos;
	logic [10:0]      ram_addr;
	logic             ram_we;
	logic [7:0]       ram_q;
	logic [2:0]       pal;
	logic             mirror;

	assign cpu_dout = ram_q;

	scroll_regs u_regs (
		.clk       (clk),
		.reset     (reset),
		.scrpos_cs (scrpos_cs),
		.cpu_addr  (cpu_addr[3:0]),
		.cpu_din   (cpu_din),
		.ofs       (ofs)
	);

	scroll_position u_position (
		.clk   (clk),
		.reset (reset),
		.h     (h),
		.v     (v),
		.flip  (flip),
		.ofs   (ofs),
		.pos   (pos)
	);

	tile_fetch_fsm u_fetch (
		.clk       (clk),
		.reset     (reset),
		.pos       (pos),
		.flip      (flip),
		.scr_cs    (scr_cs),
		.rd        (rd),
		.cpu_addr  (cpu_addr),
		.ram_addr  (ram_addr),
		.ram_we    (ram_we),
		.ram_q     (ram_q),
		.cpu_ready (cpu_ready),
		.rom_addr  (rom_addr),
		.pal       (pal),
		.mirror    (mirror)
	);

	tile_ram #(.RAM_AW(RAM_AW)) u_ram (
		.clk  (clk),
		.addr (ram_addr),
		.din  (cpu_din),
		.we   (ram_we),
		.q    (ram_q)
	);

	pixel_shifter u_shifter (
		.clk      (clk),
		.reset    (reset),
		.phase    (pos.h[2:0]),
		.rom_data (rom_data),
		.pal      (pal),
		.mirror   (mirror),
		.pixel    (pixel)
	);

endmodule

// File: testbench/scroll_layer_tb.sv
`timescale 1ns/1ps

module scroll_layer_tb;
	import scroll_pkg::*;

	localparam int MAX_CYCLES = 20000;	// About four lines per test plus margin
	localparam logic [31:0] SEED = 32'hd6165e00;

	logic        clk = 1'b0;
	logic        reset = 1'b1;
	logic [10:0] cpu_addr = '0;
	logic [7:0]  cpu_din = '0;
	logic [7:0]  cpu_dout;
	logic        rd = 1'b1;
	logic        scr_cs = 1'b0;
	logic        scrpos_cs = 1'b0;
	logic        flip = 1'b0;
	logic [8:0]  h = '0;
	logic [7:0]  v = '0;
	logic        cpu_ready;
	logic [14:0] rom_addr;
	logic [23:0] rom_data = '0;
	pixel_t      pixel;

	// Reference copies of what the CPU has written
	logic [7:0]  shadow [2048];
	logic [8:0]  ofs_h = '0;
	logic [8:0]  ofs_v = '0;
	logic        flip_m = 1'b0;
	logic [7:0]  line_v = '0;
	logic        chk = 1'b0;
	logic [31:0] rng = SEED;

	// Expected results, stamped with the cycle they are due
	int          addr_due [64] = '{default: -1};
	logic [14:0] addr_exp [64];
	int          px_due [64] = '{default: -1};
	pixel_t      px_exp [64];

	int    cyc = 0;
	int    cpu_errors = 0;
	int    scan_errors = 0;
	int    n_checks = 0;
	string test_name = "none";

	scroll_layer #(.RAM_AW(11)) uut (
		.clk       (clk),
		.reset     (reset),
		.cpu_addr  (cpu_addr),
		.cpu_din   (cpu_din),
		.cpu_dout  (cpu_dout),
		.rd        (rd),
		.scr_cs    (scr_cs),
		.scrpos_cs (scrpos_cs),
		.flip      (flip),
		.h         (h),
		.v         (v),
		.cpu_ready (cpu_ready),
		.rom_addr  (rom_addr),
		.rom_data  (rom_data),
		.pixel     (pixel)
	);

	always #5 clk = ~clk;

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x ^= x << 13;
		x ^= x >> 17;
		x ^= x << 5;
		return x;
	endfunction

	function automatic logic [23:0] rom_word(input logic [14:0] a);
		logic [31:0] s;
		logic [23:0] w;
		s = SEED ^ {17'd0, a};
		for (int i = 0; i < 3; i++) begin
			s = xorshift(s);
			w[i*8 +: 8] = s[7:0];
		end
		return w;
	endfunction

	always @(posedge clk) begin
		rom_data <= rom_word(rom_addr);	// ROM model, one clock late
	end

	always @(posedge clk) begin
		cyc <= cyc + 1;
		if (cyc >= MAX_CYCLES) begin
			$display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
			$display("TEST FAILED");
			$finish;
		end
	end

	// Predict rom_addr and the eight pixels for a beam sample taken at edge n
	task automatic expect_tile(input logic [8:0] x, input logic [7:0] y, input int n);
		logic [8:0]  hsum;
		logic [8:0]  vsum;
		logic [8:0]  sh;
		logic [7:0]  code;
		tile_attr_t  attr;
		logic        mir;
		logic        rf;
		logic [14:0] a;
		logic [23:0] w;
		logic [2:0]  b;
		pixel_t      px;
		hsum = ofs_h + {x[8], x[7:0] ^ {8{flip_m}}};
		vsum = ofs_v + {1'b0, y ^ {8{flip_m}}};
		sh = {hsum[8:3], hsum[2:0] ^ {3{flip_m}}};
		if (sh[2:0] == 3'd3) begin
			code = shadow[{1'b0, sh[8:4], vsum[8:4]}];
			attr = tile_attr_t'(shadow[{1'b1, sh[8:4], vsum[8:4]}]);
			mir = ~attr.hflip ^ flip_m;
			rf = attr.vflip ^ flip_m;
			a = {attr.code_hi, code, sh[3] ^ mir, vsum[3:0] ^ {4{rf}}};
			addr_due[6'(n + 2)] = n + 2;
			addr_exp[6'(n + 2)] = a;
			w = rom_word(a);
			for (int i = 0; i < 8; i++) begin
				b = mir ? 3'(i) : 3'(7 - i);	// Mirrored tiles go LSB first
				px.pal = attr.pal;
				px.col = {w[{2'b00, b}], w[{2'b01, b}], w[{2'b10, b}]};
				px_due[6'(n + 18 + i)] = n + 18 + i;
				px_exp[6'(n + 18 + i)] = px;
			end
		end
	endtask

	// Beam, one pixel per clock
	always @(posedge clk) begin
		if (reset) begin
			h <= '0;
			v <= '0;
		end else begin
			h <= h + 9'd1;
			if (h == 9'd511)
				v <= line_v;
			if (chk && h >= 9'd8 && h < 9'd480)	// Whole pipeline inside one line
				expect_tile(h, v, cyc);
		end
	end

	task automatic check_byte(input logic [7:0] exp, input logic [7:0] act);
		if (act !== exp) begin
			$display("MISMATCH %s: expected %h, actual %h", test_name, exp, act);
			cpu_errors++;
		end
	endtask

	task automatic check_addr(input logic [14:0] exp, input logic [14:0] act);
		if (act !== exp) begin
			$display("MISMATCH %s rom_addr: expected %h, actual %h", test_name, exp, act);
			scan_errors++;
		end
		n_checks++;
	endtask

	task automatic check_pixel(input pixel_t exp, input pixel_t act);
		if (act !== exp) begin
			$display("MISMATCH %s pixel: expected %h, actual %h", test_name, exp, act);
			scan_errors++;
		end
		n_checks++;
	endtask

	always @(negedge clk) begin
		if (addr_due[6'(cyc)] == cyc)
			check_addr(addr_exp[6'(cyc)], rom_addr);
		if (px_due[6'(cyc)] == cyc)
			check_pixel(px_exp[6'(cyc)], pixel);
	end

	task automatic cpu_access(input logic [10:0] a, input logic [7:0] d, input logic is_rd,
			output logic [7:0] q);
		int waited;
		@(posedge clk);
		cpu_addr <= a;
		cpu_din <= d;
		rd <= is_rd;
		scr_cs <= 1'b1;
		waited = 0;
		do begin
			@(negedge clk);
			waited++;
		end while (!cpu_ready && waited < 12);
		if (!cpu_ready) begin
			$display("cpu_ready never rose within 12 clocks for address %h", a);
			cpu_errors++;
		end
		q = cpu_dout;
		@(posedge clk);
		scr_cs <= 1'b0;
		rd <= 1'b1;
		if (!is_rd)
			shadow[a] = d;
	endtask

	task automatic cpu_write(input logic [10:0] a, input logic [7:0] d);
		logic [7:0] unused;
		cpu_access(a, d, 1'b0, unused);
	endtask

	task automatic scroll_reg(input logic [2:0] idx, input logic [7:0] d);
		@(posedge clk);
		scrpos_cs <= 1'b1;
		cpu_addr <= {7'd0, 1'b1, idx};
		cpu_din <= d;
		@(posedge clk);
		scrpos_cs <= 1'b0;
	endtask

	task automatic set_scroll(input logic [8:0] hs, input logic [8:0] vs);
		scroll_reg(3'd0, hs[7:0]);
		scroll_reg(3'd1, {7'd0, hs[8]});
		scroll_reg(3'd2, vs[7:0]);
		scroll_reg(3'd3, {7'd0, vs[8]});
		ofs_h = hs;
		ofs_v = vs;
	endtask

	// Random codes and attributes for all 32 tiles of a row
	task automatic fill_row(input logic [4:0] row, input logic codes, input logic hflip_val);
		tile_attr_t attr;
		for (int col = 0; col < 32; col++) begin
			rng = xorshift(rng);
			attr = tile_attr_t'(rng[15:8]);
			attr.hflip = hflip_val;
			if (codes)
				cpu_write({1'b0, 5'(col), row}, rng[7:0]);
			cpu_write({1'b1, 5'(col), row}, attr);
		end
	endtask

	task automatic sweep_line(input logic [7:0] lv);
		line_v <= lv;
		do @(posedge clk); while (h != 9'd511);
		repeat (511) @(posedge clk);
	endtask

	task automatic pause_checks();
		chk <= 1'b0;
		repeat (40) @(posedge clk);	// Let tiles in flight drain
	endtask

	task automatic resume_checks();
		repeat (8) @(posedge clk);
		chk <= 1'b1;
	endtask

	task automatic test_cpu_rw();
		logic [10:0] addrs [6];
		logic [7:0]  q;
		test_name = "cpu_rw";
		addrs = '{11'h000, 11'h7ff, 11'h155, 11'h3a2, 11'h6c1, 11'h480};
		for (int i = 0; i < 6; i++) begin
			rng = xorshift(rng);
			cpu_write(addrs[i], rng[7:0]);
		end
		for (int i = 0; i < 6; i++) begin
			cpu_access(addrs[i], 8'h00, 1'b1, q);
			check_byte(shadow[addrs[i]], q);
		end
	endtask

	// Row 2 scanned at v 34 with zero offsets
	task automatic test_pixel_order();
		test_name = "pixel_order";
		pause_checks();
		fill_row(5'd2, 1'b1, 1'b1);
		set_scroll(9'd0, 9'd0);
		sweep_line(8'd34);
		resume_checks();
		sweep_line(8'd34);
	endtask

	task automatic test_scroll_addr();
		test_name = "scroll_addr";
		pause_checks();
		set_scroll(9'h1a5, 9'h1f3);	// v 50 wraps onto row 2
		sweep_line(8'd50);
		resume_checks();
		sweep_line(8'd50);
	endtask

	task automatic test_tile_hflip();
		test_name = "tile_hflip";
		pause_checks();
		fill_row(5'd2, 1'b0, 1'b0);
		set_scroll(9'd0, 9'd0);
		sweep_line(8'd34);
		resume_checks();
		sweep_line(8'd34);
	endtask

	task automatic test_screen_flip();
		test_name = "screen_flip";
		pause_checks();
		flip <= 1'b1;
		flip_m <= 1'b1;
		sweep_line(8'd218);	// Inverted v 37 is row 2
		resume_checks();
		sweep_line(8'd218);
		pause_checks();
		flip <= 1'b0;
		flip_m <= 1'b0;
	endtask

	task automatic test_cpu_during_scan();
		logic [10:0] a;
		test_name = "cpu_during_scan";
		pause_checks();
		fill_row(5'd6, 1'b1, 1'b1);
		sweep_line(8'd34);
		resume_checks();
		a = {1'b0, 5'd5, 5'd6};
		fork
			sweep_line(8'd34);
			begin
				repeat (60) @(posedge clk);
				cpu_write(a, ~shadow[a]);
			end
		join
		sweep_line(8'd98);	// Row 6 with the new code
	endtask

	initial begin
		repeat (2) @(posedge clk);
		reset <= 1'b0;
		test_cpu_rw();
		test_pixel_order();
		test_scroll_addr();
		test_tile_hflip();
		test_screen_flip();
		test_cpu_during_scan();
		pause_checks();
		$display("errors: cpu %0d, scan %0d (scan checks %0d)", cpu_errors, scan_errors,
			n_checks);
		if (cpu_errors == 0 && scan_errors == 0 && n_checks > 0) begin
			$display("TEST OK");
		end else begin
			if (n_checks == 0)
				$display("No scan results were checked");
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

// File: files.f
hw/scroll_pkg.sv
hw/scroll_regs.sv
hw/scroll_position.sv
hw/tile_ram.sv
hw/tile_fetch_fsm.sv
hw/pixel_shifter.sv
hw/scroll_layer.sv
testbench/scroll_layer_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the scroll layer testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 \
	-f files.f \
	--top-module scroll_layer_tb \
	-Mdir obj_dir

out=$(./obj_dir/Vscroll_layer_tb)
echo "$out"

if echo "$out" | grep -q "^TEST OK$"; then
	exit 0
else
	exit 1
fi
